//--- Bender.yml
package:
  name: sdr_scan

sources:
  - source/sdr_scan_pkg.sv
  - source/sdr_bus_pkg.sv
  - source/idx_stream_if.sv
  - source/sdr_regs.sv
  - source/sdr_bit_scanner.sv
  - source/sdr_idx_fifo.sv
  - source/sdr_idx_collector.sv
  - source/sdr_top.sv
  - target: test
    files:
      - tb/tb_sdr.sv

//--- project.f
source/sdr_scan_pkg.sv
source/sdr_bus_pkg.sv
source/idx_stream_if.sv
source/sdr_regs.sv
source/sdr_bit_scanner.sv
source/sdr_idx_fifo.sv
source/sdr_idx_collector.sv
source/sdr_top.sv
tb/tb_sdr.sv

//--- source/idx_stream_if.sv
interface idx_stream_if
	import sdr_scan_pkg::*;
();
	logic     valid;
	logic     ready;
	sdr_idx_t idx;
	logic     last;
	// empty scan marker, rides with last
	logic     none;

	modport sender (
		output valid, idx, last, none,
		input  ready
	);

	modport receiver (
		input  valid, idx, last, none,
		output ready
	);

endinterface

//--- source/sdr_bit_scanner.sv
module sdr_bit_scanner
	import sdr_scan_pkg::*;
(
	input  logic           sdr_control,
	input  logic           rst_n,
	input  logic           start,
	output sdr_word_addr_t word_addr,
	input  sdr_word_t      word_data,
	idx_stream_if.sender   out
);
	localparam int             bit_w     = $clog2(word_bits);
	localparam sdr_word_addr_t last_addr = sdr_word_addr_t'(num_words - 1);

	scan_state_t      state_q;
	sdr_word_addr_t   addr_q;
	sdr_word_t        copy_q;
	logic             pend_q;
	sdr_idx_t         pend_idx_q;
	logic [bit_w-1:0] low_bit;
	sdr_idx_t         found_idx;
	logic             out_free;

	function automatic logic [bit_w-1:0] lowest_set(input sdr_word_t w);
		logic [bit_w-1:0] pos;
		pos = '0;
		for (int i = word_bits - 1; i >= 0; i--) begin
			if (w[i])
				pos = bit_w'(i);
		end
		return pos;
	endfunction

	assign low_bit   = lowest_set(copy_q);
	assign found_idx = sdr_idx_t'({addr_q, low_bit});
	assign out_free  = !out.valid || out.ready;

	// word 0 while idle, else the word after the current one
	assign word_addr = (state_q == st_idle) ? '0 : addr_q + 1'b1;

	always_ff @(posedge sdr_control or negedge rst_n) begin
		if (!rst_n) begin
			state_q    <= st_idle;
			addr_q     <= '0;
			copy_q     <= '0;
			pend_q     <= 1'b0;
			pend_idx_q <= '0;
			out.valid  <= 1'b0;
			out.idx    <= '0;
			out.last   <= 1'b0;
			out.none   <= 1'b0;
		end else begin
			if (out.valid && out.ready)
				out.valid <= 1'b0;
			case (state_q)
				st_idle: begin
					if (start) begin
						addr_q  <= '0;
						copy_q  <= word_data;
						pend_q  <= 1'b0;
						state_q <= st_scan;
					end
				end
				st_scan: begin
					if (copy_q == '0) begin
						if (addr_q == last_addr) begin
							state_q <= st_finish;
						end else begin
							addr_q <= addr_q + 1'b1;
							copy_q <= word_data;
						end
					end else if (!pend_q || out_free) begin
						// one position held back until we know if it is the final one
						pend_q     <= 1'b1;
						pend_idx_q <= found_idx;
						copy_q     <= copy_q & (copy_q - 1'b1);
						if (pend_q) begin
							out.valid <= 1'b1;
							out.idx   <= pend_idx_q;
							out.last  <= 1'b0;
							out.none  <= 1'b0;
						end
					end
				end
				st_finish: begin
					if (out_free) begin
						out.valid <= 1'b1;
						out.idx   <= pend_q ? pend_idx_q : '0;
						out.last  <= 1'b1;
						out.none  <= !pend_q;
						pend_q    <= 1'b0;
						state_q   <= st_idle;
					end
				end
				default: state_q <= st_idle;
			endcase
		end
	end

endmodule

//--- source/sdr_bus_pkg.sv
package sdr_bus_pkg;

	// word address on the wishbone side
	typedef logic [5:0] sdr_adr_t;

	localparam sdr_adr_t adr_ctrl       = 6'd32;
	localparam sdr_adr_t adr_status     = 6'd33;
	localparam sdr_adr_t adr_index_base = 6'd48;

	localparam int index_words = 16;

	typedef enum logic [2:0] {
		region_none,
		region_data,
		region_ctrl,
		region_status,
		region_index
	} reg_region_t;

	// low byte of a ctrl write
	typedef enum logic [7:0] {
		op_nop   = 8'h00,
		op_start = 8'h01
	} ctrl_op_t;

endpackage

//--- source/sdr_idx_collector.sv
module sdr_idx_collector
	import sdr_scan_pkg::*;
#(
	parameter int max_idx = 31
) (
	input  logic           sdr_control,
	input  logic           rst_n,
	input  logic           start,
	idx_stream_if.receiver in,
	input  logic           idx_rd,
	input  logic [3:0]     idx_word,
	output sdr_word_t      idx_data,
	output sdr_status_t    status,
	output logic           busy
);
	localparam int store_words = 16;

	coll_state_t state_q;
	sdr_status_t status_q;
	sdr_word_t   store_q [store_words];
	logic        take;

	// single port store, a host read blocks the stream for that cycle
	assign in.ready = !idx_rd;
	assign take     = in.valid && in.ready && (state_q == coll_run);
	assign busy     = (state_q == coll_run);
	assign status   = status_q;
	assign idx_data = store_q[idx_word];

	always_ff @(posedge sdr_control or negedge rst_n) begin
		if (!rst_n) begin
			state_q  <= coll_idle;
			status_q <= '0;
			for (int i = 0; i < store_words; i++)
				store_q[i] <= '0;
		end else begin
			case (state_q)
				coll_idle: begin
					if (start) begin
						status_q <= '0;
						for (int i = 0; i < store_words; i++)
							store_q[i] <= '0;
						state_q <= coll_run;
					end
				end
				coll_run: begin
					if (take && !in.none) begin
						status_q.total_ones <= status_q.total_ones + 1'b1;
						if (status_q.total_ones >= 17'(max_idx))
							status_q.overflow <= 1'b1;
						if (status_q.idx_count < 8'(max_idx)) begin
							// even count low half, odd count high half
							if (status_q.idx_count[0])
								store_q[status_q.idx_count[4:1]][31:16] <= in.idx;
							else
								store_q[status_q.idx_count[4:1]][15:0] <= in.idx;
							status_q.idx_count <= status_q.idx_count + 1'b1;
						end
					end
					if (take && in.last) begin
						status_q.done <= 1'b1;
						state_q       <= coll_idle;
					end
				end
				default: state_q <= coll_idle;
			endcase
		end
	end

endmodule

//--- source/sdr_idx_fifo.sv
module sdr_idx_fifo
	import sdr_scan_pkg::*;
#(
	parameter int fifo_depth = 4
) (
	input  logic           sdr_control,
	input  logic           rst_n,
	idx_stream_if.receiver in,
	idx_stream_if.sender   out
);
	localparam int ptr_w = $clog2(fifo_depth);
	localparam int cnt_w = $clog2(fifo_depth + 1);

	typedef struct packed {
		logic     none;
		logic     last;
		sdr_idx_t idx;
	} entry_t;

	entry_t           mem [fifo_depth];
	logic [ptr_w-1:0] wr_ptr_q;
	logic [ptr_w-1:0] rd_ptr_q;
	logic [cnt_w-1:0] count_q;
	logic             push;
	logic             pop;

	assign in.ready  = (count_q != cnt_w'(fifo_depth));
	assign out.valid = (count_q != '0);
	assign out.idx   = mem[rd_ptr_q].idx;
	assign out.last  = mem[rd_ptr_q].last;
	assign out.none  = mem[rd_ptr_q].none;

	assign push = in.valid && in.ready;
	assign pop  = out.valid && out.ready;

	always_ff @(posedge sdr_control) begin
		if (push)
			mem[wr_ptr_q] <= '{none: in.none, last: in.last, idx: in.idx};
	end

	always_ff @(posedge sdr_control or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({push, pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

//--- source/sdr_regs.sv
module sdr_regs
	import sdr_scan_pkg::*;
	import sdr_bus_pkg::*;
(
	input  logic                           sdr_control,
	input  logic                           rst_n,
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  sdr_adr_t                       wb_adr,
	input  sdr_word_t                      wb_dat_w,
	output sdr_word_t                      wb_dat_r,
	output logic                           wb_ack,
	input  sdr_word_addr_t                 word_addr,
	output sdr_word_t                      word_data,
	output logic                           start,
	input  logic                           busy,
	input  sdr_status_t                    status,
	output logic                           idx_rd,
	output logic [$clog2(index_words)-1:0] idx_word,
	input  sdr_word_t                      idx_data
);
	reg_region_t region;
	sdr_word_t   data_q [num_words];
	sdr_word_t   rd_mux;
	logic        req;
	logic        wr_ok;

	// new strobe, not yet answered
	assign req = wb_cyc && wb_stb && !wb_ack;

	// writes locked out while a scan runs
	assign wr_ok = req && wb_we && !busy;

	always_comb begin
		if (!wb_adr[5])
			region = region_data;
		else if (wb_adr == adr_ctrl)
			region = region_ctrl;
		else if (wb_adr == adr_status)
			region = region_status;
		else if (wb_adr >= adr_index_base)
			region = region_index;
		else
			region = region_none;
	end

	assign word_data = data_q[word_addr];

	assign idx_rd   = req && !wb_we && (region == region_index);
	assign idx_word = wb_adr[$clog2(index_words)-1:0];

	always_comb begin
		case (region)
			region_data:   rd_mux = data_q[sdr_word_addr_t'(wb_adr)];
			// ctrl reads back busy in bit 0
			region_ctrl:   rd_mux = sdr_word_t'(busy);
			region_status: rd_mux = status;
			region_index:  rd_mux = idx_data;
			default:       rd_mux = '0;
		endcase
	end

	always_ff @(posedge sdr_control or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			start  <= 1'b0;
		end else begin
			wb_ack <= req;
			start  <= wr_ok && (region == region_ctrl)
				&& (ctrl_op_t'(wb_dat_w[7:0]) == op_start);
		end
	end

	always_ff @(posedge sdr_control) begin
		if (req && !wb_we)
			wb_dat_r <= rd_mux;
	end

	always_ff @(posedge sdr_control or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_words; i++)
				data_q[i] <= '0;
		end else if (wr_ok && (region == region_data)) begin
			data_q[sdr_word_addr_t'(wb_adr)] <= wb_dat_w;
		end
	end

endmodule

//--- source/sdr_scan_pkg.sv
package sdr_scan_pkg;

	// vector geometry, 32 words of 32 bits
	localparam int num_words = 32;
	localparam int word_bits = 32;

	typedef logic [word_bits-1:0]         sdr_word_t;
	typedef logic [$clog2(num_words)-1:0] sdr_word_addr_t;
	typedef logic [15:0]                  sdr_idx_t;

	typedef struct packed {
		logic        done;
		logic        spare_30;
		logic        overflow;
		logic [3:0]  spare_28_25;
		logic [16:0] total_ones;
		logic [7:0]  idx_count;
	} sdr_status_t;

	typedef enum logic [1:0] {
		st_idle,
		st_scan,
		st_finish
	} scan_state_t;

	typedef enum logic {
		coll_idle,
		coll_run
	} coll_state_t;

endpackage

//--- source/sdr_top.sv
module sdr_top
	import sdr_scan_pkg::*;
	import sdr_bus_pkg::*;
#(
	parameter int max_idx    = 31,
	parameter int fifo_depth = 4
) (
	input  logic      sdr_control,
	input  logic      rst_n,
	input  logic      wb_cyc,
	input  logic      wb_stb,
	input  logic      wb_we,
	input  sdr_adr_t  wb_adr,
	input  sdr_word_t wb_dat_w,
	output sdr_word_t wb_dat_r,
	output logic      wb_ack
);
	sdr_word_addr_t                 word_addr;
	sdr_word_t                      word_data;
	logic                           start;
	logic                           busy;
	sdr_status_t                    status;
	logic                           idx_rd;
	logic [$clog2(index_words)-1:0] idx_word;
	sdr_word_t                      idx_data;

	idx_stream_if scan_s ();
	idx_stream_if coll_s ();

	sdr_regs i_regs (
		.sdr_control (sdr_control),
		.rst_n       (rst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.word_addr   (word_addr),
		.word_data   (word_data),
		.start       (start),
		.busy        (busy),
		.status      (status),
		.idx_rd      (idx_rd),
		.idx_word    (idx_word),
		.idx_data    (idx_data)
	);

	sdr_bit_scanner i_scanner (
		.sdr_control (sdr_control),
		.rst_n       (rst_n),
		.start       (start),
		.word_addr   (word_addr),
		.word_data   (word_data),
		.out         (scan_s.sender)
	);

	sdr_idx_fifo #(.fifo_depth(fifo_depth)) i_fifo (
		.sdr_control (sdr_control),
		.rst_n       (rst_n),
		.in          (scan_s.receiver),
		.out         (coll_s.sender)
	);

	sdr_idx_collector #(.max_idx(max_idx)) i_collector (
		.sdr_control (sdr_control),
		.rst_n       (rst_n),
		.start       (start),
		.in          (coll_s.receiver),
		.idx_rd      (idx_rd),
		.idx_word    (idx_word),
		.idx_data    (idx_data),
		.status      (status),
		.busy        (busy)
	);

endmodule

//--- tb/tb_sdr.sv
module tb_sdr
	import sdr_scan_pkg::*;
	import sdr_bus_pkg::*;
();
	localparam int kept_max        = 31;
	localparam int num_random      = 20;
	localparam int num_scans       = 1 + 3 + 1 + num_random + 1;
	localparam int watchdog_cycles = 2000 * num_scans;

	typedef sdr_word_t vector_t [num_words];
	typedef sdr_word_t index_t [index_words];

	logic      sdr_control;
	logic      rst_n;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	sdr_adr_t  wb_adr;
	sdr_word_t wb_dat_w;
	sdr_word_t wb_dat_r;
	logic      wb_ack;

	sdr_top i_dut (.*);

	initial begin
		sdr_control = 1'b0;
		forever #10 sdr_control = ~sdr_control;
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Test failures found");
		$fatal(1);
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge sdr_control);
		abort_run("watchdog expired before the tests finished");
	end

	task automatic write_reg(input sdr_adr_t adr, input sdr_word_t data);
		int waited;
		@(negedge sdr_control);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_w = data;
		waited   = 0;
		do begin
			@(negedge sdr_control);
			waited++;
			if (!wb_ack && waited > 8)
				abort_run("a bus write was never acknowledged");
		end while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic read_reg(input sdr_adr_t adr, output sdr_word_t data);
		int waited;
		@(negedge sdr_control);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		waited = 0;
		do begin
			@(negedge sdr_control);
			waited++;
			if (!wb_ack && waited > 8)
				abort_run("a bus read was never acknowledged");
		end while (!wb_ack);
		// read data is valid alongside ack
		data   = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic check_status(input sdr_status_t got, input sdr_status_t exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: status %h, expected %h", $time, got, exp));
	endtask

	task automatic check_index(input int n, input sdr_word_t got, input sdr_word_t exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: index word %0d is %h, expected %h",
				$time, n, got, exp));
	endtask

	task automatic check_word(input sdr_adr_t adr, input sdr_word_t got, input sdr_word_t exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: data word %0d reads %h, expected %h",
				$time, adr, got, exp));
	endtask

	// positions in ascending order, first kept_max packed two per word
	function automatic sdr_status_t model_scan(input vector_t vec, output index_t idx_exp);
		int          total;
		int          count;
		int          pos;
		sdr_status_t st;
		total = 0;
		count = 0;
		idx_exp = '{default: '0};
		for (int w = 0; w < num_words; w++) begin
			for (int b = 0; b < word_bits; b++) begin
				if (vec[w][b]) begin
					pos = w * word_bits + b;
					if (count < kept_max) begin
						if (count % 2 == 0)
							idx_exp[count / 2][15:0] = pos[15:0];
						else
							idx_exp[count / 2][31:16] = pos[15:0];
						count++;
					end
					total++;
				end
			end
		end
		st             = '0;
		st.done        = 1'b1;
		st.overflow    = (total > kept_max);
		st.total_ones  = 17'(total);
		st.idx_count   = 8'(count);
		return st;
	endfunction

	// mostly empty words, a few single bits
	function automatic sdr_word_t random_word();
		int pick;
		pick = $urandom_range(0, 15);
		if (pick < 10)
			return '0;
		else if (pick < 15)
			return (sdr_word_t'(1) << $urandom_range(0, 31))
				| (sdr_word_t'(1) << $urandom_range(0, 31));
		else
			return $urandom & $urandom & $urandom;
	endfunction

	task automatic load_vector(input vector_t vec);
		for (int w = 0; w < num_words; w++)
			write_reg(sdr_adr_t'(w), vec[w]);
	endtask

	task automatic wait_done();
		sdr_word_t rd;
		int        polls;
		polls = 0;
		read_reg(adr_status, rd);
		while (!rd[31]) begin
			if (polls >= 600)
				abort_run("the scan never reported done");
			read_reg(adr_status, rd);
			polls++;
		end
	endtask

	task automatic compare_results(input vector_t vec);
		index_t      idx_exp;
		sdr_status_t st_exp;
		sdr_word_t   rd;
		st_exp = model_scan(vec, idx_exp);
		read_reg(adr_status, rd);
		check_status(sdr_status_t'(rd), st_exp);
		for (int n = 0; n < index_words; n++) begin
			read_reg(adr_index_base + sdr_adr_t'(n), rd);
			check_index(n, rd, idx_exp[n]);
		end
	endtask

	task automatic run_scan(input vector_t vec);
		write_reg(adr_ctrl, sdr_word_t'(op_start));
		wait_done();
		compare_results(vec);
	endtask

	initial begin
		vector_t   vec;
		sdr_word_t rd;
		void'($urandom(32'he17a_98ac));
		rst_n    = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		repeat (4) @(negedge sdr_control);
		rst_n = 1'b1;

		// all zero, straight from reset
		vec = '{default: '0};
		for (int w = 0; w < num_words; w++) begin
			read_reg(sdr_adr_t'(w), rd);
			check_word(sdr_adr_t'(w), rd, '0);
		end
		read_reg(adr_status, rd);
		check_status(sdr_status_t'(rd), '0);
		for (int n = 0; n < index_words; n++) begin
			read_reg(adr_index_base + sdr_adr_t'(n), rd);
			check_index(n, rd, '0);
		end
		run_scan(vec);

		vec    = '{default: '0};
		vec[0] = 32'h0000_ffff;
		load_vector(vec);
		run_scan(vec);

		vec     = '{default: '0};
		vec[0]  = 32'h0000_0001;
		vec[5]  = 32'h8000_0000;
		vec[12] = 32'h0001_0100;
		vec[31] = 32'h1000_0000;
		load_vector(vec);
		run_scan(vec);

		vec     = '{default: '0};
		vec[29] = 32'h0000_00ff;
		vec[30] = 32'h00f0_0f00;
		vec[31] = 32'h8000_0001;
		load_vector(vec);
		run_scan(vec);

		// 64 set bits, count capped
		vec = '{default: 32'h0000_0003};
		load_vector(vec);
		run_scan(vec);

		for (int t = 0; t < num_random; t++) begin
			foreach (vec[w])
				vec[w] = random_word();
			load_vector(vec);
			run_scan(vec);
		end

		// dense vector keeps the scan long enough for the traffic below
		foreach (vec[w])
			vec[w] = $urandom;
		load_vector(vec);
		write_reg(adr_ctrl, sdr_word_t'(op_start));
		for (int w = 0; w < 8; w++)
			write_reg(sdr_adr_t'(w), ~vec[w]);
		write_reg(adr_ctrl, sdr_word_t'(op_start));
		for (int n = 0; n < 2 * index_words; n++)
			read_reg(adr_index_base + sdr_adr_t'(n % index_words), rd);
		read_reg(adr_ctrl, rd);
		if (!rd[0])
			abort_run("the scan ended before the writes during the scan were issued");
		wait_done();
		compare_results(vec);
		for (int w = 0; w < num_words; w++) begin
			read_reg(sdr_adr_t'(w), rd);
			check_word(sdr_adr_t'(w), rd, vec[w]);
		end

		$display("All tests passed!");
		$finish;
	end

endmodule
